//--- common/dma_loop_pkg.sv
package dma_loop_pkg;

    // bus and burst geometry
    localparam int data_w           = 64;
    localparam int addr_w           = 32;
    localparam int burst_len        = 16;
    localparam int bursts_per_frame = 4;
    localparam int buff_num         = 3;

    localparam logic [addr_w-1:0] burst_bytes  = addr_w'(burst_len * 8);
    localparam logic [addr_w-1:0] frame_bytes  = addr_w'(burst_len * 8 * bursts_per_frame);
    localparam logic [addr_w-1:0] wr_base_addr = 32'h0200_0000;
    localparam logic [addr_w-1:0] rd_base_addr = 32'h0200_0000;

    // fifo sizing, in beats
    localparam int wr_fifo_depth = 4 * burst_len;
    localparam int rd_fifo_depth = 8 * burst_len;
    localparam int rd_fill_limit = 4 * burst_len;
    localparam int wr_cnt_w      = $clog2(wr_fifo_depth + 1);
    localparam int rd_cnt_w      = $clog2(rd_fifo_depth + 1);

    localparam int start_frames = 4;    // frame ends seen before reading
    localparam int pixel_w      = 24;
    localparam int post_w       = 16;

    // fixed burst attributes, shared by aw and ar
    localparam logic [7:0] axi_len        = 8'(burst_len - 1);
    localparam logic [2:0] axi_size       = 3'd3;    // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [3:0] axi_cache      = 4'b0010;

    typedef logic [1:0] buf_idx_t;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } burst_state_e;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              valid;
    } axi_addr_ch_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
        logic              valid;
    } axi_w_ch_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
        logic              valid;
    } axi_r_ch_t;

    typedef struct packed {
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic [3:0] cache;
    } axi_attr_t;

    typedef struct packed {
        logic               vs;
        logic               de;
        logic [pixel_w-1:0] data;
    } pixel_in_t;

    typedef struct packed {
        logic req;
        logic burst_now;
        logic burst_end;
    } arb_status_t;

endpackage

//--- src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 64,
    parameter int depth = 64
) (
    input  logic                         M_AXI_ACLK,
    input  logic                         M_AXI_ARESETN,
    input  logic                         flush,
    input  logic                         wr_en,
    input  logic [width-1:0]             wr_data,
    input  logic                         rd_en,
    output logic [width-1:0]             rd_data,
    output logic [$clog2(depth+1)-1:0]   count,
    output logic                         full,
    output logic                         empty
);

    localparam int ptr_w = $clog2(depth);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign full    = (count == depth);
    assign empty   = (count == 0);
    assign do_wr   = wr_en && !full;     // overflowing beats are dropped
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];        // show-ahead

    always_ff @(posedge M_AXI_ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- write_channel/frame_write_ctrl.sv
`timescale 1ns/1ps

module frame_write_ctrl (
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  dma_loop_pkg::pixel_in_t           pixel_in,
    input  logic [dma_loop_pkg::wr_cnt_w-1:0] fifo_count,
    input  logic [dma_loop_pkg::data_w-1:0]   fifo_data,
    input  logic                              awready,
    input  logic                              wready,
    input  logic                              wr_grant,
    output logic                              fifo_wr_en,
    output logic [dma_loop_pkg::data_w-1:0]   fifo_wr_data,
    output logic                              fifo_flush,
    output logic                              fifo_rd_en,
    output dma_loop_pkg::axi_addr_ch_t        aw,
    output dma_loop_pkg::axi_w_ch_t           w,
    output logic                              bready,
    output dma_loop_pkg::arb_status_t         wr_status,
    output dma_loop_pkg::buf_idx_t            wr_buf,
    output logic                              frame_end
);

    dma_loop_pkg::burst_state_e              state;
    logic                                    vs_d;
    logic                                    frame_end_d;
    logic [dma_loop_pkg::addr_w-1:0]         frame_base;
    logic [dma_loop_pkg::addr_w-1:0]         aw_offset;
    logic [$clog2(dma_loop_pkg::burst_len)-1:0] beat_cnt;
    logic                                    burst_start;
    logic                                    w_hs;

    // pixel side
    assign fifo_wr_en   = pixel_in.de;
    assign fifo_wr_data = {{(dma_loop_pkg::data_w - dma_loop_pkg::pixel_w){1'b0}}, pixel_in.data};
    assign fifo_flush   = pixel_in.vs && !vs_d;     // new frame, drop leftovers
    assign frame_end    = !pixel_in.vs && vs_d;

    // burst handshakes
    assign wr_status.req       = (fifo_count >= dma_loop_pkg::burst_len);
    assign burst_start         = wr_status.req && wr_grant && (state == dma_loop_pkg::st_idle);
    assign wr_status.burst_now = (state != dma_loop_pkg::st_idle);
    assign w_hs                = w.valid && wready;
    assign wr_status.burst_end = w_hs && w.last;

    assign aw.addr    = dma_loop_pkg::wr_base_addr + aw_offset;
    assign aw.valid   = (state == dma_loop_pkg::st_addr);
    assign w.valid    = (state == dma_loop_pkg::st_data);
    assign w.last     = (beat_cnt == dma_loop_pkg::burst_len - 1);
    assign w.data     = fifo_data;
    assign fifo_rd_en = w_hs;

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            vs_d        <= 1'b0;
            frame_end_d <= 1'b0;
            bready      <= 1'b0;
        end else begin
            vs_d        <= pixel_in.vs;
            frame_end_d <= frame_end;
            bready      <= 1'b1;
        end
    end

    // buffer rotation on each frame end, index runs 1..buff_num
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_buf     <= 2'd1;
            frame_base <= '0;
        end else if (frame_end) begin
            if (wr_buf == dma_loop_pkg::buff_num) begin
                wr_buf     <= 2'd1;
                frame_base <= '0;
            end else begin
                wr_buf     <= wr_buf + 1'b1;
                frame_base <= frame_base + dma_loop_pkg::frame_bytes;
            end
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state     <= dma_loop_pkg::st_idle;
            aw_offset <= '0;
            beat_cnt  <= '0;
        end else begin
            if (frame_end_d) begin
                aw_offset <= frame_base;      // new base lands one cycle after the edge
            end else if (aw.valid && awready) begin
                aw_offset <= aw_offset + dma_loop_pkg::burst_bytes;
            end
            case (state)
                dma_loop_pkg::st_idle: if (burst_start) state <= dma_loop_pkg::st_addr;
                dma_loop_pkg::st_addr: if (awready) state <= dma_loop_pkg::st_data;
                dma_loop_pkg::st_data: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;    // wraps to 0 after last
                        if (w.last) state <= dma_loop_pkg::st_idle;
                    end
                end
                default: state <= dma_loop_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- read_channel/frame_read_ctrl.sv
`timescale 1ns/1ps

module frame_read_ctrl (
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  dma_loop_pkg::buf_idx_t            wr_buf,
    input  logic                              frame_end,
    input  logic [dma_loop_pkg::rd_cnt_w-1:0] rd_fifo_count,
    input  logic                              rd_fifo_full,
    input  logic                              arready,
    input  dma_loop_pkg::axi_r_ch_t           r,
    input  logic                              rd_grant,
    output dma_loop_pkg::axi_addr_ch_t        ar,
    output logic                              rready,
    output dma_loop_pkg::arb_status_t         rd_status,
    output logic                              rd_fifo_wr_en,
    output logic [dma_loop_pkg::data_w-1:0]   rd_fifo_wr_data,
    output logic                              read_active
);

    localparam int beat_w  = $clog2(dma_loop_pkg::burst_len);
    localparam int burst_w = $clog2(dma_loop_pkg::bursts_per_frame);
    localparam int start_w = $clog2(dma_loop_pkg::start_frames + 1);

    dma_loop_pkg::burst_state_e      state;
    dma_loop_pkg::buf_idx_t          rd_buf;
    logic [dma_loop_pkg::addr_w-1:0] rd_frame_base;
    logic [dma_loop_pkg::addr_w-1:0] ar_offset;
    logic [start_w-1:0]              start_cnt;
    logic [beat_w-1:0]               beat_cnt;
    logic [burst_w-1:0]              burst_cnt;
    logic                            r_hs;
    logic                            frame_done;
    logic                            burst_start;

    assign r_hs       = r.valid && rready;
    assign frame_done = r_hs && (beat_cnt == dma_loop_pkg::burst_len - 1)
                        && (burst_cnt == dma_loop_pkg::bursts_per_frame - 1);

    assign rd_status.req       = read_active && (rd_fifo_count < dma_loop_pkg::rd_fill_limit);
    assign burst_start         = rd_status.req && rd_grant && (state == dma_loop_pkg::st_idle);
    assign rd_status.burst_now = (state != dma_loop_pkg::st_idle);
    assign rd_status.burst_end = r_hs && r.last;

    assign ar.addr         = dma_loop_pkg::rd_base_addr + ar_offset;
    assign ar.valid        = (state == dma_loop_pkg::st_addr);
    assign rready          = (state == dma_loop_pkg::st_data);
    assign rd_fifo_wr_en   = r_hs;
    assign rd_fifo_wr_data = r.data;

    // startup gate, waits for a few complete frames in memory
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            start_cnt   <= '0;
            read_active <= 1'b0;
        end else begin
            if (frame_end && start_cnt != dma_loop_pkg::start_frames) begin
                start_cnt <= start_cnt + 1'b1;
            end
            if (start_cnt == dma_loop_pkg::start_frames && !rd_fifo_full) begin
                read_active <= 1'b1;
            end
        end
    end

    // read the buffer just before the one being written
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            rd_buf        <= '0;
            rd_frame_base <= '0;
        end else begin
            rd_buf        <= (wr_buf > 2'd1) ? wr_buf - 2'd2 : 2'd2;    // 0-based
            rd_frame_base <= dma_loop_pkg::frame_bytes * rd_buf;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state     <= dma_loop_pkg::st_idle;
            ar_offset <= '0;
            beat_cnt  <= '0;
            burst_cnt <= '0;
        end else begin
            if (frame_done) begin
                ar_offset <= rd_frame_base;
            end else if (ar.valid && arready) begin
                ar_offset <= ar_offset + dma_loop_pkg::burst_bytes;
            end
            if (r_hs) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == dma_loop_pkg::burst_len - 1) begin
                    burst_cnt <= burst_cnt + 1'b1;    // wraps at frame end
                end
            end
            case (state)
                dma_loop_pkg::st_idle: if (burst_start) state <= dma_loop_pkg::st_addr;
                dma_loop_pkg::st_addr: if (arready) state <= dma_loop_pkg::st_data;
                dma_loop_pkg::st_data: if (r_hs && r.last) state <= dma_loop_pkg::st_idle;
                default:               state <= dma_loop_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- read_channel/post_unpack.sv
`timescale 1ns/1ps

module post_unpack (
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  logic                              read_active,
    input  logic [dma_loop_pkg::rd_cnt_w-1:0] fifo_count,
    input  logic [dma_loop_pkg::data_w-1:0]   fifo_data,
    input  logic                              fifo_empty,
    input  logic                              post_de,
    output logic                              fifo_rd_en,
    output logic                              post_start,
    output logic [dma_loop_pkg::post_w-1:0]   post_data
);

    logic [1:0] hw_sel;    // halfword within the current beat
    logic       step;

    // an empty fifo holds the output where it is
    assign step       = post_de && post_start && !fifo_empty;
    assign fifo_rd_en = step && (hw_sel == 2'd3);

    // sticky once a full burst is buffered
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            post_start <= 1'b0;
        end else if (read_active && fifo_count >= dma_loop_pkg::burst_len) begin
            post_start <= 1'b1;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            hw_sel <= '0;
        end else if (step) begin
            hw_sel <= hw_sel + 1'b1;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (step) begin
            post_data <= fifo_data[hw_sel * dma_loop_pkg::post_w +: dma_loop_pkg::post_w];
        end
    end

endmodule

//--- src/frame_dma_top.sv
`timescale 1ns/1ps

module frame_dma_top (
    input  logic                      M_AXI_ACLK,
    input  logic                      M_AXI_ARESETN,
    output dma_loop_pkg::axi_addr_ch_t m_axi_aw,
    input  logic                      m_axi_awready,
    output dma_loop_pkg::axi_w_ch_t   m_axi_w,
    input  logic                      m_axi_wready,
    input  logic                      m_axi_bvalid,
    output logic                      m_axi_bready,
    output dma_loop_pkg::axi_addr_ch_t m_axi_ar,
    input  logic                      m_axi_arready,
    input  dma_loop_pkg::axi_r_ch_t   m_axi_r,
    output logic                      m_axi_rready,
    output dma_loop_pkg::axi_attr_t   m_axi_attr,
    input  logic                      wr_grant,
    input  logic                      rd_grant,
    output dma_loop_pkg::arb_status_t wr_status,
    output dma_loop_pkg::arb_status_t rd_status,
    input  dma_loop_pkg::pixel_in_t   pixel_in,
    input  logic                      post_de,
    output logic                      post_start,
    output logic [dma_loop_pkg::post_w-1:0] post_data
);

    logic                                wr_fifo_wr_en;
    logic [dma_loop_pkg::data_w-1:0]     wr_fifo_wr_data;
    logic                                wr_fifo_flush;
    logic                                wr_fifo_rd_en;
    logic [dma_loop_pkg::data_w-1:0]     wr_fifo_rd_data;
    logic [dma_loop_pkg::wr_cnt_w-1:0]   wr_fifo_count;
    logic                                rd_fifo_wr_en;
    logic [dma_loop_pkg::data_w-1:0]     rd_fifo_wr_data;
    logic                                rd_fifo_rd_en;
    logic [dma_loop_pkg::data_w-1:0]     rd_fifo_rd_data;
    logic [dma_loop_pkg::rd_cnt_w-1:0]   rd_fifo_count;
    logic                                rd_fifo_full;
    logic                                rd_fifo_empty;
    dma_loop_pkg::buf_idx_t              wr_buf;
    logic                                frame_end;
    logic                                read_active;

    // write responses are not checked, so b only needs bready
    assign m_axi_attr = '{len:   dma_loop_pkg::axi_len,
                          size:  dma_loop_pkg::axi_size,
                          burst: dma_loop_pkg::axi_burst_incr,
                          cache: dma_loop_pkg::axi_cache};

    frame_write_ctrl u_write_ctrl (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .M_AXI_ARESETN(M_AXI_ARESETN),
        .pixel_in     (pixel_in),
        .fifo_count   (wr_fifo_count),
        .fifo_data    (wr_fifo_rd_data),
        .awready      (m_axi_awready),
        .wready       (m_axi_wready),
        .wr_grant     (wr_grant),
        .fifo_wr_en   (wr_fifo_wr_en),
        .fifo_wr_data (wr_fifo_wr_data),
        .fifo_flush   (wr_fifo_flush),
        .fifo_rd_en   (wr_fifo_rd_en),
        .aw           (m_axi_aw),
        .w            (m_axi_w),
        .bready       (m_axi_bready),
        .wr_status    (wr_status),
        .wr_buf       (wr_buf),
        .frame_end    (frame_end)
    );

    sync_fifo #(
        .width(dma_loop_pkg::data_w),
        .depth(dma_loop_pkg::wr_fifo_depth)
    ) u_wr_fifo (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .M_AXI_ARESETN(M_AXI_ARESETN),
        .flush        (wr_fifo_flush),
        .wr_en        (wr_fifo_wr_en),
        .wr_data      (wr_fifo_wr_data),
        .rd_en        (wr_fifo_rd_en),
        .rd_data      (wr_fifo_rd_data),
        .count        (wr_fifo_count),
        .full         (),
        .empty        ()
    );

    frame_read_ctrl u_read_ctrl (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .wr_buf         (wr_buf),
        .frame_end      (frame_end),
        .rd_fifo_count  (rd_fifo_count),
        .rd_fifo_full   (rd_fifo_full),
        .arready        (m_axi_arready),
        .r              (m_axi_r),
        .rd_grant       (rd_grant),
        .ar             (m_axi_ar),
        .rready         (m_axi_rready),
        .rd_status      (rd_status),
        .rd_fifo_wr_en  (rd_fifo_wr_en),
        .rd_fifo_wr_data(rd_fifo_wr_data),
        .read_active    (read_active)
    );

    sync_fifo #(
        .width(dma_loop_pkg::data_w),
        .depth(dma_loop_pkg::rd_fifo_depth)
    ) u_rd_fifo (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .M_AXI_ARESETN(M_AXI_ARESETN),
        .flush        (1'b0),
        .wr_en        (rd_fifo_wr_en),
        .wr_data      (rd_fifo_wr_data),
        .rd_en        (rd_fifo_rd_en),
        .rd_data      (rd_fifo_rd_data),
        .count        (rd_fifo_count),
        .full         (rd_fifo_full),
        .empty        (rd_fifo_empty)
    );

    post_unpack u_post_unpack (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .M_AXI_ARESETN(M_AXI_ARESETN),
        .read_active  (read_active),
        .fifo_count   (rd_fifo_count),
        .fifo_data    (rd_fifo_rd_data),
        .fifo_empty   (rd_fifo_empty),
        .post_de      (post_de),
        .fifo_rd_en   (rd_fifo_rd_en),
        .post_start   (post_start),
        .post_data    (post_data)
    );

endmodule

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [31:0] seed_init = 32'h5f21_ee2d
) (
    input  logic                       M_AXI_ACLK,
    input  logic                       M_AXI_ARESETN,
    input  dma_loop_pkg::axi_addr_ch_t aw,
    output logic                       awready,
    input  dma_loop_pkg::axi_w_ch_t    w,
    output logic                       wready,
    output logic                       bvalid,
    input  logic                       bready,
    input  dma_loop_pkg::axi_addr_ch_t ar,
    output logic                       arready,
    output dma_loop_pkg::axi_r_ch_t    r,
    input  logic                       rready
);

    logic [63:0] mem [logic [31:0]];
    logic [31:0] waddr;
    logic [31:0] raddr;
    int          rleft;
    integer      seed;

    // unwritten locations read back a pattern built from the address
    function automatic logic [63:0] mem_read(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a, ~a};
    endfunction

    initial begin
        seed    = seed_init;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        arready = 1'b0;
        r       = '0;
    end

    always @(posedge M_AXI_ACLK) begin : slave
        logic [31:0] a;
        int          left;
        a    = raddr;
        left = rleft;
        if (!M_AXI_ARESETN) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            r       <= '0;
            rleft   <= 0;
        end else begin
            if (aw.valid && awready) waddr <= aw.addr;
            if (w.valid && wready) begin
                mem[waddr] = w.data;
                waddr <= waddr + 32'd8;
                if (w.last) bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            awready <= ($random(seed) & 3) != 0;    // stall about one cycle in 4
            wready  <= ($random(seed) & 3) != 0;
            arready <= ($random(seed) & 1) != 0;
            if (r.valid && rready) begin
                a    = a + 32'd8;
                left = left - 1;
            end
            if (ar.valid && arready) begin
                a    = ar.addr;
                left = dma_loop_pkg::burst_len;
            end
            raddr <= a;
            rleft <= left;
            if (r.valid && !rready) begin
                r <= r;    // hold beat until taken
            end else if (left > 0 && ($random(seed) & 3) != 0) begin
                r <= '{data: mem_read(a), last: (left == 1), valid: 1'b1};
            end else begin
                r.valid <= 1'b0;
            end
        end
    end

endmodule

//--- tb/tb_frame_dma.sv
`timescale 1ns/1ps

module tb_frame_dma;

    localparam int n_frames   = 8;
    localparam int frame_pix  = dma_loop_pkg::bursts_per_frame * dma_loop_pkg::burst_len;
    localparam int out_target = 512;

    logic M_AXI_ACLK;
    logic M_AXI_ARESETN;
    dma_loop_pkg::axi_addr_ch_t m_axi_aw, m_axi_ar;
    dma_loop_pkg::axi_w_ch_t    m_axi_w;
    dma_loop_pkg::axi_r_ch_t    m_axi_r;
    dma_loop_pkg::axi_attr_t    m_axi_attr;
    dma_loop_pkg::arb_status_t  wr_status, rd_status;
    dma_loop_pkg::pixel_in_t    pixel_in;
    logic m_axi_awready, m_axi_wready, m_axi_bvalid, m_axi_bready;
    logic m_axi_arready, m_axi_rready;
    logic wr_grant, rd_grant, post_de, post_start;
    logic [15:0] post_data;

    integer seed;
    int     errors, timeouts;
    int     w_beats, aw_n, ar_n, r_bursts, falls, out_checks;
    logic [63:0] pix_q[$];
    logic [15:0] hw_q[$];
    logic [31:0] pass_base;
    logic [15:0] out_exp;
    logic out_pending, vs_prev, wg_prev, rg_prev, wbn_prev, rbn_prev;
    logic rd_busy, out_of_reset;

    frame_dma_top i_frame_dma_top (.*);

    axi_mem_model u_mem (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .M_AXI_ARESETN(M_AXI_ARESETN),
        .aw           (m_axi_aw),
        .awready      (m_axi_awready),
        .w            (m_axi_w),
        .wready       (m_axi_wready),
        .bvalid       (m_axi_bvalid),
        .bready       (m_axi_bready),
        .ar           (m_axi_ar),
        .arready      (m_axi_arready),
        .r            (m_axi_r),
        .rready       (m_axi_rready)
    );

    always #2 M_AXI_ACLK = ~M_AXI_ACLK;

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // random grants and post side enable
    always @(posedge M_AXI_ACLK) begin
        wr_grant <= ($random(seed) & 1) != 0;
        rd_grant <= ($random(seed) & 1) != 0;
        post_de  <= post_start && (($random(seed) & 7) == 0);
    end

    // reference model sampled mid cycle where everything is settled
    always @(negedge M_AXI_ACLK) begin : monitor
        logic [31:0] exp_addr;
        logic [31:0] off;
        logic        w_last_hs;
        if (M_AXI_ARESETN) begin
            // queue sizes here still match the fifo fill levels
            check_val(wr_status.req, pix_q.size() >= dma_loop_pkg::burst_len, "write request");
            if (ar_n > 0) begin
                check_val(rd_status.req,
                          (hw_q.size() + 3) / 4 < dma_loop_pkg::rd_fill_limit, "read request");
            end else if (falls < 4) begin
                check_val(rd_status.req, 0, "read request before fourth frame end");
            end
            check_val(m_axi_rready, rd_busy, "rready outside read burst");
            if (out_of_reset) check_val(m_axi_bready, 1, "bready");
            out_of_reset = 1'b1;
            w_last_hs = m_axi_w.valid && m_axi_wready
                        && ((w_beats % dma_loop_pkg::burst_len) == dma_loop_pkg::burst_len - 1);
            if (out_pending) begin
                check_val(post_data, out_exp, "post halfword");
                out_checks++;
                out_pending = 1'b0;
            end
            if (post_de && post_start && hw_q.size() > 0) begin
                out_exp     = hw_q.pop_front();
                out_pending = 1'b1;
            end
            if (pixel_in.de) pix_q.push_back(64'(pixel_in.data));
            if (vs_prev && !pixel_in.vs) falls++;
            vs_prev = pixel_in.vs;
            if (m_axi_w.valid && m_axi_wready) begin
                if (pix_q.size() == 0) begin
                    errors++;
                    $display("write beat at %0t has no matching input pixel", $time);
                end else begin
                    check_val(m_axi_w.data, pix_q.pop_front(), "write data");
                end
                check_val(m_axi_w.last,
                          (w_beats % dma_loop_pkg::burst_len) == dma_loop_pkg::burst_len - 1,
                          "wlast");
                w_beats++;
            end
            if (m_axi_aw.valid && m_axi_awready) begin
                exp_addr = dma_loop_pkg::wr_base_addr
                         + 32'((aw_n / 4) % 3) * dma_loop_pkg::frame_bytes
                         + 32'(aw_n % 4) * dma_loop_pkg::burst_bytes;
                check_val(m_axi_aw.addr, exp_addr, "write address");
                aw_n++;
            end
            if (m_axi_ar.valid && m_axi_arready) begin
                check_val(falls >= 4, 1, "read before fourth frame end");
                if (ar_n % 4 == 0) begin
                    pass_base = m_axi_ar.addr;
                    off = m_axi_ar.addr - dma_loop_pkg::rd_base_addr;
                    check_val(off == 0 || off == dma_loop_pkg::frame_bytes
                              || off == 2 * dma_loop_pkg::frame_bytes, 1, "read pass base");
                    check_val(off / dma_loop_pkg::frame_bytes != 32'(falls % 3), 1,
                              "read pass hits write buffer");
                end else begin
                    check_val(m_axi_ar.addr,
                              pass_base + 32'(ar_n % 4) * dma_loop_pkg::burst_bytes,
                              "read address step");
                end
                ar_n++;
                rd_busy = 1'b1;
            end
            if (m_axi_r.valid && m_axi_rready) begin
                for (int i = 0; i < 4; i++) hw_q.push_back(m_axi_r.data[i*16 +: 16]);
                if (m_axi_r.last) begin
                    r_bursts++;
                    rd_busy = 1'b0;
                end
            end
            if (post_start) check_val(r_bursts > 0, 1, "post start before a read burst");
            if (wr_status.burst_now && !wbn_prev) check_val(wg_prev, 1, "write burst w/o grant");
            if (rd_status.burst_now && !rbn_prev) check_val(rg_prev, 1, "read burst w/o grant");
            check_val(wr_status.burst_end, w_last_hs, "write burst_end");
            check_val(rd_status.burst_end,
                      m_axi_r.valid && m_axi_rready && m_axi_r.last, "read burst_end");
            wg_prev  = wr_grant;
            rg_prev  = rd_grant;
            wbn_prev = wr_status.burst_now;
            rbn_prev = rd_status.burst_now;
        end
    end

    task automatic run_frames();
        int n;
        for (int f = 0; f < n_frames; f++) begin
            for (int i = 0; i < frame_pix; i++) begin
                @(posedge M_AXI_ACLK);
                pixel_in <= '{vs: 1'b0, de: 1'b1, data: 24'($random(seed))};
                repeat (2) begin
                    @(posedge M_AXI_ACLK);
                    pixel_in <= '{vs: 1'b0, de: 1'b0, data: '0};
                end
            end
            n = 0;
            while (w_beats < (f + 1) * frame_pix && n < 2000) begin    // drain before vs
                @(posedge M_AXI_ACLK);
                n++;
            end
            if (w_beats < (f + 1) * frame_pix) begin
                timeouts++;
                $display("timeout: write FIFO did not drain in frame %0d", f);
                return;
            end
            repeat (4) begin
                @(posedge M_AXI_ACLK);
                pixel_in <= '{vs: 1'b1, de: 1'b0, data: '0};
            end
            @(posedge M_AXI_ACLK);
            pixel_in <= '{vs: 1'b0, de: 1'b0, data: '0};
            repeat (8) @(posedge M_AXI_ACLK);
        end
        n = 0;
        while (out_checks < out_target && n < 20000) begin
            @(posedge M_AXI_ACLK);
            n++;
        end
        if (out_checks < out_target) begin
            timeouts++;
            $display("timeout: only %0d output halfwords seen", out_checks);
        end
    endtask

    initial begin
        seed          = 32'h5f21_ee2d;
        M_AXI_ACLK    = 1'b0;
        M_AXI_ARESETN = 1'b0;
        pixel_in      = '0;
        wr_grant      = 1'b0;
        rd_grant      = 1'b0;
        post_de       = 1'b0;
        vs_prev       = 1'b0;
        out_pending   = 1'b0;
        rd_busy       = 1'b0;
        out_of_reset  = 1'b0;
        {wg_prev, rg_prev, wbn_prev, rbn_prev} = '0;
        repeat (5) @(posedge M_AXI_ACLK);
        M_AXI_ARESETN <= 1'b1;
        // len is beats minus one, 8 byte beats, INCR, cache 0010
        check_val(m_axi_attr.len, 8'(dma_loop_pkg::burst_len - 1), "attr len");
        check_val(m_axi_attr.size, 3'd3, "attr size");
        check_val(m_axi_attr.burst, 2'b01, "attr burst");
        check_val(m_axi_attr.cache, 4'b0010, "attr cache");
        run_frames();
        if (ar_n == 0) begin
            errors++;
            $display("no read burst was issued after the fourth frame end");
        end
        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- compile.f
common/dma_loop_pkg.sv
src/sync_fifo.sv
write_channel/frame_write_ctrl.sv
read_channel/frame_read_ctrl.sv
read_channel/post_unpack.sv
src/frame_dma_top.sv
tb/axi_mem_model.sv
tb/tb_frame_dma.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_frame_dma -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Finished with no errors"
